// File: src/clint_pkg.sv
package clint_pkg;

    // --------------------------------------------------
    // Basic types
    // --------------------------------------------------

    // Byte offset inside the CLINT window
    typedef logic [15:0] reg_addr_t;

    // All CLINT registers are read and written as 64 bits
    typedef logic [63:0] reg_data_t;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------

    // One msip word per core, starting at the bottom of the window
    localparam reg_addr_t MSIP_BASE     = 16'h0000;

    // One 64-bit mtimecmp per core
    localparam reg_addr_t MTIMECMP_BASE = 16'h4000;

    // Single shared real-time counter
    localparam reg_addr_t MTIME_BASE    = 16'hBFF8;

    // Byte step between the registers of two neighbouring cores
    localparam reg_addr_t REG_STRIDE    = 16'd8;

    // --------------------------------------------------
    // Access decode
    // --------------------------------------------------

    // Which register set a request hits
    // SEL_NONE covers idle cycles and rejected accesses
    typedef enum logic [1:0] {
        SEL_NONE     = 2'd0,
        SEL_MSIP     = 2'd1,
        SEL_MTIMECMP = 2'd2,
        SEL_MTIME    = 2'd3
    } reg_sel_e;

endpackage

// File: src/rtc_tick_sync.sv
module rtc_tick_sync (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic rtc_i,
    output logic tick_o
);

    // First two stages resolve metastability of the async RTC input
    logic sync_q1;
    logic sync_q2;

    // Previous synchronized level, for edge detection
    logic prev_q;

    // --------------------------------------------------
    // Synchronizer and edge register
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
            prev_q  <= 1'b0;
        end else begin
            sync_q1 <= rtc_i;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    // One-cycle pulse on a low-to-high change of the synchronized level
    assign tick_o = sync_q2 & ~prev_q;

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    // A single RTC edge must never count twice
    // Holds as long as the RTC is slower than half the core clock
    a_tick_single : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        tick_o |=> !tick_o
    ) else $error("rtc_tick_sync: tick high in two consecutive cycles");

endmodule

// File: src/clint_bus_port.sv
module clint_bus_port #(
    parameter int unsigned NR_CORES = 2
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        req_i,
    input  logic                        we_i,
    input  clint_pkg::reg_addr_t        addr_i,
    input  clint_pkg::reg_data_t        wdata_i,
    input  clint_pkg::reg_data_t        rdata_cur_i,
    output clint_pkg::reg_sel_e         sel_o,
    output logic [IDX_W-1:0]            core_idx_o,
    output logic                        wr_en_o,
    output clint_pkg::reg_data_t        wdata_o,
    output logic                        rsp_valid_o,
    output logic                        err_o,
    output clint_pkg::reg_data_t        rdata_o
);

    // Core index width, never below one bit
    localparam int unsigned IDX_W = (NR_CORES > 1) ? $clog2(NR_CORES) : 1;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    clint_pkg::reg_sel_e  region;
    clint_pkg::reg_addr_t offset;
    clint_pkg::reg_addr_t idx_full;
    logic                 aligned;
    logic                 idx_ok;
    logic                 good;

    always_comb begin
        region = clint_pkg::SEL_NONE;
        offset = '0;
        // mtime is a single word, every other offset is a per-core array
        if (addr_i == clint_pkg::MTIME_BASE) begin
            region = clint_pkg::SEL_MTIME;
        end else if (addr_i < clint_pkg::MTIMECMP_BASE) begin
            region = clint_pkg::SEL_MSIP;
            offset = addr_i - clint_pkg::MSIP_BASE;
        end else if (addr_i < clint_pkg::MTIME_BASE) begin
            region = clint_pkg::SEL_MTIMECMP;
            offset = addr_i - clint_pkg::MTIMECMP_BASE;
        end
    end

    // Word index inside the region, full width so large offsets are caught
    assign idx_full = offset / clint_pkg::REG_STRIDE;

    assign aligned  = (addr_i & (clint_pkg::REG_STRIDE - 16'd1)) == '0;

    // mtime has no core index, so it always passes this check
    assign idx_ok   = (region == clint_pkg::SEL_MTIME) || (idx_full < 16'(NR_CORES));

    assign good     = aligned && (region != clint_pkg::SEL_NONE) && idx_ok;

    // --------------------------------------------------
    // Outputs towards the register block
    // --------------------------------------------------

    // Nothing is selected in idle cycles or on a bad access
    assign sel_o      = (req_i && good) ? region : clint_pkg::SEL_NONE;
    assign core_idx_o = idx_full[IDX_W-1:0];
    assign wr_en_o    = req_i && we_i && good;
    assign wdata_o    = wdata_i;

    // --------------------------------------------------
    // Response register, one cycle after the request
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_o <= 1'b0;
            err_o       <= 1'b0;
            rdata_o     <= '0;
        end else begin
            rsp_valid_o <= req_i;
            err_o       <= req_i && !good;
            // Writes and rejected reads answer with zero
            if (req_i && !we_i && good) begin
                rdata_o <= rdata_cur_i;
            end else begin
                rdata_o <= '0;
            end
        end
    end

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    // Fixed latency, every request gets exactly one response
    a_rsp_latency : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o == $past(req_i)
    ) else $error("clint_bus_port: response not one cycle after request");

endmodule

// File: src/clint_regs.sv
module clint_regs #(
    parameter int unsigned NR_CORES = 2
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 tick_i,
    input  logic                                 wr_en_i,
    input  clint_pkg::reg_sel_e                  sel_i,
    input  logic [IDX_W-1:0]                     core_idx_i,
    input  clint_pkg::reg_data_t                 wdata_i,
    output clint_pkg::reg_data_t                 rdata_o,
    output clint_pkg::reg_data_t                 mtime_o,
    output clint_pkg::reg_data_t [NR_CORES-1:0]  mtimecmp_o,
    output logic [NR_CORES-1:0]                  msip_o
);

    // Core index width, never below one bit
    localparam int unsigned IDX_W = (NR_CORES > 1) ? $clog2(NR_CORES) : 1;

    // Register state
    clint_pkg::reg_data_t                mtime_q;
    clint_pkg::reg_data_t [NR_CORES-1:0] mtimecmp_q;
    logic [NR_CORES-1:0]                 msip_q;

    // Per-register write strobes
    logic mtime_we;
    logic mtimecmp_we;
    logic msip_we;

    assign mtime_we    = wr_en_i && (sel_i == clint_pkg::SEL_MTIME);
    assign mtimecmp_we = wr_en_i && (sel_i == clint_pkg::SEL_MTIMECMP);
    assign msip_we     = wr_en_i && (sel_i == clint_pkg::SEL_MSIP);

    // --------------------------------------------------
    // Real-time counter
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else if (mtime_we) begin
            // Software write wins, a tick in the same cycle is dropped
            mtime_q <= wdata_i;
        end else if (tick_i) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // --------------------------------------------------
    // Per-core compare and software interrupt bits
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '0;
        end else if (mtimecmp_we) begin
            mtimecmp_q[core_idx_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            msip_q <= '0;
        end else if (msip_we) begin
            // Only bit 0 of the word is implemented
            msip_q[core_idx_i] <= wdata_i[0];
        end
    end

    // --------------------------------------------------
    // Read mux
    // --------------------------------------------------

    // Current contents, captured by the bus port at the end of the cycle
    always_comb begin
        rdata_o = '0;
        case (sel_i)
            clint_pkg::SEL_MTIME: begin
                rdata_o = mtime_q;
            end
            clint_pkg::SEL_MTIMECMP: begin
                rdata_o = mtimecmp_q[core_idx_i];
            end
            clint_pkg::SEL_MSIP: begin
                // msip reads back zero-extended
                rdata_o = {63'd0, msip_q[core_idx_i]};
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

    // Straight to the comparator and to the IPI lines
    assign mtime_o    = mtime_q;
    assign mtimecmp_o = mtimecmp_q;
    assign msip_o     = msip_q;

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    // Without a write, mtime holds or steps by one per RTC tick
    // so it never runs backwards apart from the 64-bit wrap
    a_mtime_monotonic : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$past(mtime_we) |->
            (mtime_q == $past(mtime_q)) || (mtime_q == $past(mtime_q) + 64'd1)
    ) else $error("clint_regs: mtime moved without a write or a single tick");

endmodule

// File: src/timer_irq_cmp.sv
module timer_irq_cmp #(
    parameter int unsigned NR_CORES = 2
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  clint_pkg::reg_data_t                 mtime_i,
    input  clint_pkg::reg_data_t [NR_CORES-1:0]  mtimecmp_i,
    output logic [NR_CORES-1:0]                  timer_irq_o
);

    // Combinational compare result per core
    logic [NR_CORES-1:0] irq_d;

    // --------------------------------------------------
    // Compare
    // --------------------------------------------------
    always_comb begin
        for (int unsigned i = 0; i < NR_CORES; i++) begin
            // A compare value of zero means the timer is disarmed
            irq_d[i] = (mtimecmp_i[i] != '0) && (mtime_i >= mtimecmp_i[i]);
        end
    end

    // --------------------------------------------------
    // Registered interrupt lines
    // --------------------------------------------------

    // Level stays posted until software moves mtimecmp or mtime
    // so that the compare turns false
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_irq_o <= '0;
        end else begin
            timer_irq_o <= irq_d;
        end
    end

endmodule

// File: src/clint_top.sv
module clint_top #(
    parameter int unsigned NR_CORES = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  rtc_i,
    input  logic                  req_i,
    input  logic                  we_i,
    input  clint_pkg::reg_addr_t  addr_i,
    input  clint_pkg::reg_data_t  wdata_i,
    output logic                  rsp_valid_o,
    output logic                  err_o,
    output clint_pkg::reg_data_t  rdata_o,
    output logic [NR_CORES-1:0]   timer_irq_o,
    output logic [NR_CORES-1:0]   ipi_o
);

    // Core index width, never below one bit
    localparam int unsigned IDX_W = (NR_CORES > 1) ? $clog2(NR_CORES) : 1;

    // --------------------------------------------------
    // Internal wiring
    // --------------------------------------------------
    clint_pkg::reg_sel_e                 sel;
    logic [IDX_W-1:0]                    core_idx;
    logic                                wr_en;
    clint_pkg::reg_data_t                wdata;
    clint_pkg::reg_data_t                rdata_cur;
    logic                                tick;
    clint_pkg::reg_data_t                mtime;
    clint_pkg::reg_data_t [NR_CORES-1:0] mtimecmp;

    // Register port, decode and one-cycle response
    clint_bus_port #(
        .NR_CORES    (NR_CORES)
    ) u_bus_port (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rdata_cur_i (rdata_cur),
        .sel_o       (sel),
        .core_idx_o  (core_idx),
        .wr_en_o     (wr_en),
        .wdata_o     (wdata),
        .rsp_valid_o (rsp_valid_o),
        .err_o       (err_o),
        .rdata_o     (rdata_o)
    );

    // RTC edge into the core clock domain
    rtc_tick_sync u_rtc_sync (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .rtc_i  (rtc_i),
        .tick_o (tick)
    );

    // mtime, mtimecmp and msip, msip feeds the IPI lines directly
    clint_regs #(
        .NR_CORES   (NR_CORES)
    ) u_regs (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .tick_i     (tick),
        .wr_en_i    (wr_en),
        .sel_i      (sel),
        .core_idx_i (core_idx),
        .wdata_i    (wdata),
        .rdata_o    (rdata_cur),
        .mtime_o    (mtime),
        .mtimecmp_o (mtimecmp),
        .msip_o     (ipi_o)
    );

    timer_irq_cmp #(
        .NR_CORES    (NR_CORES)
    ) u_irq_cmp (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mtime_i     (mtime),
        .mtimecmp_i  (mtimecmp),
        .timer_irq_o (timer_irq_o)
    );

endmodule

// File: testbench/clint_tb.sv
module clint_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NR_CORES    = 2;
    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;

    // Register addresses used by the table
    localparam clint_pkg::reg_addr_t A_MSIP0   = clint_pkg::MSIP_BASE;
    localparam clint_pkg::reg_addr_t A_MSIP1   = clint_pkg::MSIP_BASE + 16'd8;
    localparam clint_pkg::reg_addr_t A_MSIP2   = clint_pkg::MSIP_BASE + 16'd16;
    localparam clint_pkg::reg_addr_t A_CMP0    = clint_pkg::MTIMECMP_BASE;
    localparam clint_pkg::reg_addr_t A_CMP1    = clint_pkg::MTIMECMP_BASE + 16'd8;
    localparam clint_pkg::reg_addr_t A_CMP2    = clint_pkg::MTIMECMP_BASE + 16'd16;
    localparam clint_pkg::reg_addr_t A_CMP_UNA = clint_pkg::MTIMECMP_BASE + 16'd4;
    localparam clint_pkg::reg_addr_t A_MTIME   = clint_pkg::MTIME_BASE;
    localparam clint_pkg::reg_addr_t A_UNMAP   = 16'hC000;

    typedef enum logic [1:0] {
        OP_WR,
        OP_RD,
        OP_RTC
    } op_e;

    // One table row, data holds the pulse count for RTC rows
    typedef struct {
        op_e                  op;
        clint_pkg::reg_addr_t addr;
        clint_pkg::reg_data_t data;
        clint_pkg::reg_data_t exp_rdata;
        logic                 exp_err;
        logic [1:0]           exp_tirq;
        logic [1:0]           exp_ipi;
    } row_t;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  rtc_i;
    logic                  req_i;
    logic                  we_i;
    clint_pkg::reg_addr_t  addr_i;
    clint_pkg::reg_data_t  wdata_i;
    logic                  rsp_valid_o;
    logic                  err_o;
    clint_pkg::reg_data_t  rdata_o;
    logic [NR_CORES-1:0]   timer_irq_o;
    logic [NR_CORES-1:0]   ipi_o;

    row_t       rows[$];
    logic [15:0] lfsr_q;
    logic [1:0]  ipi_model;
    int          pass_cnt;
    int          fail_cnt;
    bit          table_ready;

    clint_top #(
        .NR_CORES    (NR_CORES)
    ) uut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rtc_i       (rtc_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .err_o       (err_o),
        .rdata_o     (rdata_o),
        .timer_irq_o (timer_irq_o),
        .ipi_o       (ipi_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Random numbers
    // --------------------------------------------------

    // 16-bit Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic rand_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        return b;
    endfunction

    function automatic clint_pkg::reg_data_t rand_word();
        clint_pkg::reg_data_t w;
        w = '0;
        for (int i = 0; i < 64; i++) begin
            w = {w[62:0], rand_bit()};
        end
        return w;
    endfunction

    function automatic string op_name(input op_e op);
        case (op)
            OP_WR:   return "write";
            OP_RD:   return "read ";
            default: return "rtc  ";
        endcase
    endfunction

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    task automatic add_row(input op_e op, input clint_pkg::reg_addr_t addr,
                           input clint_pkg::reg_data_t data,
                           input clint_pkg::reg_data_t exp_rdata, input logic exp_err,
                           input logic [1:0] exp_tirq, input logic [1:0] exp_ipi);
        row_t r;
        r.op        = op;
        r.addr      = addr;
        r.data      = data;
        r.exp_rdata = exp_rdata;
        r.exp_err   = exp_err;
        r.exp_tirq  = exp_tirq;
        r.exp_ipi   = exp_ipi;
        rows.push_back(r);
    endtask

    task automatic build_fixed_table();
        // Read-back, msip keeps bit 0 only
        add_row(OP_WR, A_MSIP0, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0, 1'b0, 2'b00, 2'b01);
        add_row(OP_RD, A_MSIP0, 64'd0, 64'd1, 1'b0, 2'b00, 2'b01);
        add_row(OP_WR, A_MSIP0, 64'd2, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RD, A_MSIP0, 64'd0, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_WR, A_MSIP1, 64'd1, 64'd0, 1'b0, 2'b00, 2'b10);
        add_row(OP_RD, A_MSIP1, 64'd0, 64'd1, 1'b0, 2'b00, 2'b10);
        add_row(OP_WR, A_MSIP1, 64'd0, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_WR, A_CMP0, 64'h1234_5678_9ABC_DEF0, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RD, A_CMP0, 64'd0, 64'h1234_5678_9ABC_DEF0, 1'b0, 2'b00, 2'b00);
        add_row(OP_WR, A_CMP1, 64'hFEDC_BA98_7654_3210, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RD, A_CMP1, 64'd0, 64'hFEDC_BA98_7654_3210, 1'b0, 2'b00, 2'b00);
        add_row(OP_WR, A_MTIME, 64'h1000, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RD, A_MTIME, 64'd0, 64'h1000, 1'b0, 2'b00, 2'b00);
        // Bad accesses answer with err and zero, writes are dropped
        add_row(OP_RD, A_CMP_UNA, 64'd0, 64'd0, 1'b1, 2'b00, 2'b00);
        add_row(OP_WR, A_CMP_UNA, 64'd5, 64'd0, 1'b1, 2'b00, 2'b00);
        add_row(OP_RD, A_CMP0, 64'd0, 64'h1234_5678_9ABC_DEF0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RD, A_UNMAP, 64'd0, 64'd0, 1'b1, 2'b00, 2'b00);
        add_row(OP_WR, A_UNMAP, 64'd7, 64'd0, 1'b1, 2'b00, 2'b00);
        add_row(OP_RD, A_MSIP2, 64'd0, 64'd0, 1'b1, 2'b00, 2'b00);
        add_row(OP_WR, A_MSIP2, 64'd1, 64'd0, 1'b1, 2'b00, 2'b00);
        add_row(OP_WR, A_CMP2, 64'd5, 64'd0, 1'b1, 2'b00, 2'b00);
        // Core index 2 would alias onto core 0 if its upper bit were dropped
        add_row(OP_RD, A_CMP0, 64'd0, 64'h1234_5678_9ABC_DEF0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RD, A_MSIP0, 64'd0, 64'd0, 1'b0, 2'b00, 2'b00);
        // Timer compare, zero disarms
        add_row(OP_WR, A_MTIME, 64'd100, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_WR, A_CMP0, 64'd100, 64'd0, 1'b0, 2'b01, 2'b00);
        add_row(OP_RD, A_CMP0, 64'd0, 64'd100, 1'b0, 2'b01, 2'b00);
        add_row(OP_WR, A_CMP0, 64'd101, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_WR, A_CMP0, 64'd0, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RD, A_MTIME, 64'd0, 64'd100, 1'b0, 2'b00, 2'b00);
        // RTC counting across the 32-bit boundary
        add_row(OP_WR, A_MTIME, 64'hFFFF_FFFE, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RTC, '0, 64'd5, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RD, A_MTIME, 64'd0, 64'h1_0000_0003, 1'b0, 2'b00, 2'b00);
        add_row(OP_WR, A_CMP0, 64'h1_0000_0004, 64'd0, 1'b0, 2'b00, 2'b00);
        add_row(OP_RTC, '0, 64'd1, 64'd0, 1'b0, 2'b01, 2'b00);
        add_row(OP_RD, A_MTIME, 64'd0, 64'h1_0000_0004, 1'b0, 2'b01, 2'b00);
        add_row(OP_WR, A_CMP0, 64'd0, 64'd0, 1'b0, 2'b00, 2'b00);
        // Software interrupts, bit by bit
        add_row(OP_WR, A_MSIP0, 64'd1, 64'd0, 1'b0, 2'b00, 2'b01);
        add_row(OP_WR, A_MSIP1, 64'd1, 64'd0, 1'b0, 2'b00, 2'b11);
        add_row(OP_WR, A_MSIP0, 64'd0, 64'd0, 1'b0, 2'b00, 2'b10);
        add_row(OP_RD, A_MSIP1, 64'd0, 64'd1, 1'b0, 2'b00, 2'b10);
        add_row(OP_WR, A_MSIP1, 64'd0, 64'd0, 1'b0, 2'b00, 2'b00);
    endtask

    // Compare values get bit 63 set and mtime gets it cleared
    // so the timer lines stay low through the random rows
    task automatic add_random_pairs(input int rounds);
        clint_pkg::reg_data_t v;
        clint_pkg::reg_addr_t a;
        int core;
        ipi_model = 2'b00;
        for (int r = 0; r < rounds; r++) begin
            v = rand_word() | 64'h8000_0000_0000_0000;
            add_row(OP_WR, A_CMP0, v, 64'd0, 1'b0, 2'b00, ipi_model);
            add_row(OP_RD, A_CMP0, 64'd0, v, 1'b0, 2'b00, ipi_model);
            v = rand_word() | 64'h8000_0000_0000_0000;
            add_row(OP_WR, A_CMP1, v, 64'd0, 1'b0, 2'b00, ipi_model);
            add_row(OP_RD, A_CMP1, 64'd0, v, 1'b0, 2'b00, ipi_model);
            v = rand_word() & 64'h7FFF_FFFF_FFFF_FFFF;
            add_row(OP_WR, A_MTIME, v, 64'd0, 1'b0, 2'b00, ipi_model);
            add_row(OP_RD, A_MTIME, 64'd0, v, 1'b0, 2'b00, ipi_model);
            core = r % NR_CORES;
            a = clint_pkg::MSIP_BASE + 16'(core) * clint_pkg::REG_STRIDE;
            v = rand_word();
            ipi_model[core] = v[0];
            add_row(OP_WR, a, v, 64'd0, 1'b0, 2'b00, ipi_model);
            add_row(OP_RD, a, 64'd0, {63'd0, v[0]}, 1'b0, 2'b00, ipi_model);
        end
    endtask

    // --------------------------------------------------
    // Row execution
    // --------------------------------------------------

    // Inputs change and outputs are sampled just after the edge
    task automatic step_cycle();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic run_row(input int n, input row_t r);
        int errs;
        errs = 0;
        if (r.op == OP_RTC) begin
            // Slow enough for the two-flop synchronizer
            for (int p = 0; p < int'(r.data); p++) begin
                rtc_i = 1'b1;
                repeat (4) step_cycle();
                rtc_i = 1'b0;
                repeat (4) step_cycle();
            end
            repeat (6) step_cycle();
            if (rsp_valid_o) begin
                $display("Row %0d: response seen without a request", n);
                errs++;
            end
        end else begin
            req_i   = 1'b1;
            we_i    = (r.op == OP_WR);
            addr_i  = r.addr;
            wdata_i = r.data;
            step_cycle();
            req_i   = 1'b0;
            we_i    = 1'b0;
            addr_i  = '0;
            wdata_i = '0;
            // Response cycle
            if (!rsp_valid_o) begin
                $display("Row %0d: no response one cycle after the request", n);
                errs++;
            end
            if (rdata_o !== r.exp_rdata) begin
                $display("** Error row %0d: rdata_o expected %h got %h", n, r.exp_rdata, rdata_o);
                errs++;
            end
            if (err_o !== r.exp_err) begin
                $display("** Error row %0d: err_o expected %h got %h", n, r.exp_err, err_o);
                errs++;
            end
            step_cycle();
            if (rsp_valid_o) begin
                $display("Row %0d: extra response after the request", n);
                errs++;
            end
        end
        // Interrupt lines two cycles after the last request
        if (timer_irq_o !== r.exp_tirq) begin
            $display("** Error row %0d: timer_irq_o expected %h got %h",
                     n, r.exp_tirq, timer_irq_o);
            errs++;
        end
        if (ipi_o !== r.exp_ipi) begin
            $display("** Error row %0d: ipi_o expected %h got %h", n, r.exp_ipi, ipi_o);
            errs++;
        end
        if (errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Row %0d %s addr %h data %h: %s", n, op_name(r.op), r.addr, r.data,
                 (errs == 0) ? "ok" : "mismatch");
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        rst_ni      = 1'b0;
        rtc_i       = 1'b0;
        req_i       = 1'b0;
        we_i        = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        lfsr_q      = 16'd63027;
        build_fixed_table();
        add_random_pairs(4);
        table_ready = 1'b1;
        repeat (5) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;
        step_cycle();
        // Quiet outputs out of reset
        if (rsp_valid_o || err_o || (timer_irq_o != '0) || (ipi_o != '0)) begin
            $display("Reset: outputs not low after reset");
            fail_cnt++;
        end else begin
            $display("Reset: ok");
            pass_cnt++;
        end
        foreach (rows[i]) begin
            run_row(i, rows[i]);
        end
        $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, 40 cycles per row on average is far above the need
    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(rows.size()) * 40 * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
src/clint_pkg.sv
src/rtc_tick_sync.sv
src/clint_bus_port.sv
src/clint_regs.sv
src/timer_irq_cmp.sv
src/clint_top.sv
testbench/clint_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CLINT testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module clint_tb \
    -o clint_sim

out=$(./obj_dir/clint_sim)
echo "$out"

# The testbench prints its verdict as a line of its own
if echo "$out" | grep -q "^RESULT: PASS$"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
